// File: SpiPkg.sv
//--------------------------------------
// SPI slave unit shared definitions
// Word width, command codes and the
// header word in its two decoded views
//--------------------------------------
package SpiPkg;

	//--------------------------------------
	// Word width
	//--------------------------------------
	// SPI word and both bus data paths
	localparam int spiWordBit = 32;

	//--------------------------------------
	// Command codes, header bits [31:30]
	//--------------------------------------
	// Single register write, header then data
	localparam logic [1:0] cmdUsiWrite = 2'd0;
	// Single register read, data back on MISO
	localparam logic [1:0] cmdUsiRead = 2'd1;
	// Stream burst, header, address, data words
	localparam logic [1:0] cmdUfiBurst = 2'd2;
	// Not decoded, frame ignored
	localparam logic [1:0] cmdReserved = 2'd3;

	//--------------------------------------
	// Header word
	//--------------------------------------
	// Command sits in the same bits in both views
	typedef union packed {
		// Register access view
		struct packed {
			logic [1:0] cmd;
			logic [13:0] rsvd;
			logic [15:0] adrs;
		} usi;
		// Burst view, count of data words
		struct packed {
			logic [1:0] cmd;
			logic [13:0] rsvd;
			logic [15:0] count;
		} ufi;
	} spiHeader_u;

endpackage

// File: SpiFrameIf.sv
//--------------------------------------
// Decoded SPI frame words
// Carries words and header from the
// frame decoder to the bus executor
//--------------------------------------
`timescale 1ns/1ps

interface SpiFrameIf import SpiPkg::*; ();

	// Last completed word
	logic [spiWordBit-1:0] word;
	// Header of the current frame, held until the next one
	spiHeader_u header;
	// One cycle per completed word
	logic wordVd;
	// Position in frame, 0 is the header
	logic [15:0] wordIdx;
	// CS released
	logic frameEnd;

	// Word source
	modport decoder (
		output word, header, wordVd, wordIdx, frameEnd
	);

	// Word sink
	modport executor (
		input word, header, wordVd, wordIdx, frameEnd
	);

endinterface

// File: SpiFrameDecoder.sv
//--------------------------------------
// SPI slave frame decoder
// Samples the mode 0 pins in the system
// clock domain, builds 32-bit words MSB
// first and tracks words within a frame
//--------------------------------------
`timescale 1ns/1ps

module SpiFrameDecoder import SpiPkg::*; (
	input logic sysClk,
	input logic arstN,
	// SPI pins, asynchronous to sysClk
	input logic spiSck,
	input logic spiCsN,
	input logic spiMosi,
	// Decoded words
	SpiFrameIf.decoder frame,
	// Detected SCK rise inside a frame
	output logic sckRise
);

	localparam int bitCntBit = $clog2(spiWordBit);

	// Two-flop synchronizers
	logic [1:0] sckSync;
	logic [1:0] csSync;
	logic [1:0] mosiSync;
	// Previous synchronized levels for edges
	logic sckPrev;
	logic csPrev;
	// Bit position within the word
	logic [bitCntBit-1:0] bitCnt;
	// Completed words so far in this frame
	logic [15:0] wordCnt;
	// Word being assembled
	logic [spiWordBit-1:0] shiftReg;
	logic [spiWordBit-1:0] nextWord;
	logic csActive;
	logic sckEdge;
	logic csOff;
	logic wordFull;

	//--------------------------------------
	// Pin synchronizers
	//--------------------------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			// CS idles high, no frame
			sckSync <= '0;
			csSync <= '1;
			mosiSync <= '0;
			sckPrev <= 1'b0;
			csPrev <= 1'b1;
		end
		else
		begin
			sckSync <= {sckSync[0], spiSck};
			csSync <= {csSync[0], spiCsN};
			mosiSync <= {mosiSync[0], spiMosi};
			sckPrev <= sckSync[1];
			csPrev <= csSync[1];
		end
	end

	assign csActive = ~csSync[1];
	// Rise only counts inside a frame
	assign sckEdge = sckSync[1] & ~sckPrev & csActive;
	// CS going high ends the frame
	assign csOff = csSync[1] & ~csPrev;
	// Last bit of the word arrives on this edge
	assign wordFull = bitCnt == bitCntBit'(spiWordBit - 1);
	// MSB first, new bit enters at the bottom
	assign nextWord = {shiftReg[spiWordBit-2:0], mosiSync[1]};

	//--------------------------------------
	// Frame control
	//--------------------------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			bitCnt <= '0;
			wordCnt <= '0;
			sckRise <= 1'b0;
			frame.wordVd <= 1'b0;
			frame.frameEnd <= 1'b0;
		end
		else
		begin
			// Strobes, three cycles behind the pin edge
			sckRise <= sckEdge;
			frame.wordVd <= sckEdge & wordFull;
			frame.frameEnd <= csOff;
			if (!csActive)
			begin
				// Partial word dropped with the frame
				bitCnt <= '0;
				wordCnt <= '0;
			end
			else if (sckEdge)
			begin
				bitCnt <= wordFull ? '0 : bitCnt + 1'b1;
				// Saturate on very long bursts
				if (wordFull && wordCnt != '1)
					wordCnt <= wordCnt + 16'd1;
			end
		end
	end

	//--------------------------------------
	// Word payload
	//--------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (sckEdge)
		begin
			shiftReg <= nextWord;
			if (wordFull)
			begin
				frame.word <= nextWord;
				frame.wordIdx <= wordCnt;
				// First word of a frame is the header
				if (wordCnt == 16'd0)
					frame.header <= nextWord;
			end
		end
	end

endmodule

// File: SpiBusExecutor.sv
//--------------------------------------
// SPI frame to bus transfer executor
// Issues USI register writes and reads
// and UFI burst writes from frame words
//--------------------------------------
`timescale 1ns/1ps

module SpiBusExecutor import SpiPkg::*; #(
	parameter int busAdrsBit = 16
)(
	input logic sysClk,
	input logic arstN,
	// Decoded frame words
	SpiFrameIf.executor frame,
	// USI register bus
	input logic [spiWordBit-1:0] usiRd,
	output logic [spiWordBit-1:0] usiWd,
	output logic [busAdrsBit-1:0] usiAdrs,
	output logic usiWEd,
	// UFI stream bus
	output logic [spiWordBit-1:0] ufiWd,
	output logic [spiWordBit-1:0] ufiAdrs,
	output logic ufiWEd,
	output logic ufiWVd,
	// Read data toward MISO
	output logic [spiWordBit-1:0] rdData,
	output logic rdLoad
);

	// Command of the running frame
	logic [1:0] cmd;
	// Burst data words still expected
	logic [15:0] remain;
	// Address of the next burst word
	logic [spiWordBit-1:0] ufiNext;
	// USI read address on the bus, data next cycle
	logic rdPend;
	logic hdrVd;
	logic usiHdrVd;
	logic usiRdVd;
	logic usiWrVd;
	logic burstAdrsVd;
	logic burstDataVd;

	//--------------------------------------
	// Word classification
	//--------------------------------------
	// Header is latched with word 0, so read it directly
	assign hdrVd = frame.wordVd && frame.wordIdx == 16'd0;
	assign usiHdrVd = hdrVd && (frame.header.usi.cmd == cmdUsiWrite ||
		frame.header.usi.cmd == cmdUsiRead);
	assign usiRdVd = hdrVd && frame.header.usi.cmd == cmdUsiRead;
	assign usiWrVd = frame.wordVd && frame.wordIdx == 16'd1 && cmd == cmdUsiWrite;
	assign burstAdrsVd = frame.wordVd && frame.wordIdx == 16'd1 && cmd == cmdUfiBurst;
	// Words past the count fall through
	assign burstDataVd = frame.wordVd && frame.wordIdx >= 16'd2 && cmd == cmdUfiBurst
		&& ufiWVd && remain != 16'd0;

	//--------------------------------------
	// Frame state and strobes
	//--------------------------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			cmd <= cmdReserved;
			remain <= '0;
			usiWEd <= 1'b0;
			ufiWEd <= 1'b0;
			ufiWVd <= 1'b0;
			rdPend <= 1'b0;
			rdLoad <= 1'b0;
		end
		else
		begin
			usiWEd <= usiWrVd;
			ufiWEd <= burstDataVd;
			// Read data returns two cycles after the header
			rdPend <= usiRdVd;
			rdLoad <= rdPend;
			if (frame.frameEnd)
			begin
				// Burst cut short by CS
				cmd <= cmdReserved;
				remain <= '0;
				ufiWVd <= 1'b0;
			end
			else
			begin
				if (hdrVd)
					cmd <= frame.header.usi.cmd;
				// Count only exists in the burst view
				if (hdrVd && frame.header.ufi.cmd == cmdUfiBurst)
					remain <= frame.header.ufi.count;
				if (burstDataVd)
					remain <= remain - 16'd1;
				// Empty burst never opens the window
				if (burstAdrsVd)
					ufiWVd <= remain != 16'd0;
				else if (ufiWEd && remain == 16'd0)
					ufiWVd <= 1'b0;
			end
		end
	end

	//--------------------------------------
	// Bus payload
	//--------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (usiHdrVd)
			usiAdrs <= busAdrsBit'(frame.header.usi.adrs);
		if (usiWrVd)
			usiWd <= frame.word;
		if (rdPend)
			rdData <= usiRd;
		// Burst base from word 1
		if (burstAdrsVd)
			ufiNext <= frame.word;
		if (burstDataVd)
		begin
			ufiAdrs <= ufiNext;
			ufiWd <= frame.word;
			ufiNext <= ufiNext + spiWordBit'(4);
		end
	end

endmodule

// File: SpiMisoResult.sv
//--------------------------------------
// SPI slave MISO serializer
// Shifts USI read data out MSB first on
// detected SCK rising edges
//--------------------------------------
`timescale 1ns/1ps

module SpiMisoResult import SpiPkg::*; (
	input logic sysClk,
	input logic arstN,
	// Detected SCK rise from the decoder
	input logic sckRise,
	// CS released
	input logic frameEnd,
	// Read data from the executor
	input logic rdLoad,
	input logic [spiWordBit-1:0] rdData,
	output logic spiMiso
);

	// Word on its way out
	logic [spiWordBit-1:0] shiftReg;

	//--------------------------------------
	// Output shift register
	//--------------------------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
			shiftReg <= '0;
		// MISO idles low between frames
		else if (frameEnd)
			shiftReg <= '0;
		else if (rdLoad)
			shiftReg <= rdData;
		// Master has already sampled this bit
		else if (sckRise)
			shiftReg <= {shiftReg[spiWordBit-2:0], 1'b0};
	end

	// MSB drives the pin
	assign spiMiso = shiftReg[spiWordBit-1];

endmodule

// File: SpiSlaveUnit.sv
//--------------------------------------
// SPI slave control unit
// Turns SPI frames into USI register and
// UFI stream bus transfers
//--------------------------------------
`timescale 1ns/1ps

module SpiSlaveUnit import SpiPkg::*; #(
	parameter int busAdrsBit = 16
)(
	input logic sysClk,
	input logic arstN,
	// SPI pins
	input logic spiSck,
	input logic spiCsN,
	input logic spiMosi,
	output logic spiMiso,
	// USI register bus
	input logic [spiWordBit-1:0] usiRd,
	output logic [spiWordBit-1:0] usiWd,
	output logic [busAdrsBit-1:0] usiAdrs,
	output logic usiWEd,
	// UFI stream bus
	output logic [spiWordBit-1:0] ufiWd,
	output logic [spiWordBit-1:0] ufiAdrs,
	output logic ufiWEd,
	output logic ufiWVd
);

	// Decoder to executor words
	SpiFrameIf frame ();

	// Internal strobes
	logic sckRise;
	logic rdLoad;
	logic [spiWordBit-1:0] rdData;

	//--------------------------------------
	// Pin side
	//--------------------------------------
	SpiFrameDecoder frameDecoder (
		.sysClk (sysClk),
		.arstN (arstN),
		.spiSck (spiSck),
		.spiCsN (spiCsN),
		.spiMosi (spiMosi),
		.frame (frame.decoder),
		.sckRise (sckRise)
	);

	//--------------------------------------
	// Bus side
	//--------------------------------------
	SpiBusExecutor #(
		.busAdrsBit (busAdrsBit)
	) busExecutor (
		.sysClk (sysClk),
		.arstN (arstN),
		.frame (frame.executor),
		.usiRd (usiRd),
		.usiWd (usiWd),
		.usiAdrs (usiAdrs),
		.usiWEd (usiWEd),
		.ufiWd (ufiWd),
		.ufiAdrs (ufiAdrs),
		.ufiWEd (ufiWEd),
		.ufiWVd (ufiWVd),
		.rdData (rdData),
		.rdLoad (rdLoad)
	);

	// Read data back to the master
	SpiMisoResult misoResult (
		.sysClk (sysClk),
		.arstN (arstN),
		.sckRise (sckRise),
		.frameEnd (frame.frameEnd),
		.rdLoad (rdLoad),
		.rdData (rdData),
		.spiMiso (spiMiso)
	);

endmodule

// File: SpiClkGen.sv
//--------------------------------------
// Testbench clock and reset source
// Free running sysClk, reset held low
// for a fixed number of cycles
//--------------------------------------
`timescale 1ns/1ps

module SpiClkGen #(
	parameter int clkPeriod = 40,
	parameter int resetCycles = 16
)(
	output logic sysClk,
	output logic arstN
);

	initial
	begin
		sysClk = 1'b0;
		forever #(clkPeriod / 2) sysClk = ~sysClk;
	end

	// Release away from the active edge
	initial
	begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge sysClk);
		@(negedge sysClk);
		arstN = 1'b1;
	end

endmodule

// File: SpiUnitAssert.sv
//--------------------------------------
// SPI slave unit bus strobe properties
// Bound onto the unit top level
//--------------------------------------
`timescale 1ns/1ps

module SpiUnitAssert (
	input logic sysClk,
	input logic arstN,
	input logic spiCsN,
	input logic usiWEd,
	input logic ufiWEd,
	input logic ufiWVd
);

	// Edge detect, word strobe and bus strobe stages
	localparam int pipeDepth = 4;

	// Local copy of the CS synchronizer
	logic [1:0] csSync;
	// Saturating count of cycles with synchronized CS high
	logic [3:0] csIdle;
	// Failed property count
	int failCount = 0;

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			csSync <= '1;
			csIdle <= '0;
		end
		else
		begin
			csSync <= {csSync[0], spiCsN};
			if (!csSync[1])
				csIdle <= '0;
			else if (csIdle != '1)
				csIdle <= csIdle + 4'd1;
		end
	end

	// One bus at a time
	assert property (@(posedge sysClk) disable iff (!arstN) !(usiWEd && ufiWEd))
	else
	begin
		failCount++;
		$error("USI and UFI write strobes in the same cycle");
	end

	// Burst data only inside the write window
	assert property (@(posedge sysClk) disable iff (!arstN) ufiWEd |-> ufiWVd)
	else
	begin
		failCount++;
		$error("UFI write strobe outside the write window");
	end

	// Nothing left in flight once CS has settled high
	assert property (@(posedge sysClk) disable iff (!arstN)
		(usiWEd || ufiWEd) |-> csIdle <= 4'(pipeDepth))
	else
	begin
		failCount++;
		$error("Bus strobe long after CS went inactive");
	end

endmodule

bind SpiSlaveUnit SpiUnitAssert strobeAssert (
	.sysClk (sysClk),
	.arstN (arstN),
	.spiCsN (spiCsN),
	.usiWEd (usiWEd),
	.ufiWEd (ufiWEd),
	.ufiWVd (ufiWVd)
);

// File: SpiUnitTb.sv
//--------------------------------------
// SPI slave unit testbench
// SPI master driver, register model and
// burst monitor, frames read from a file
//--------------------------------------
`timescale 1ns/1ps

module SpiUnitTb import SpiPkg::*; ();

	// SCK half-period in sysClk cycles
	localparam int halfBit = 8;
	localparam int maxCases = 32;

	logic sysClk, arstN, spiSck, spiCsN, spiMosi, spiMiso;
	logic [31:0] usiRd, usiWd, ufiWd, ufiAdrs;
	logic [15:0] usiAdrs;
	logic usiWEd, ufiWEd, ufiWVd;
	// Four words per case for kind, address, count and value
	logic [31:0] caseMem [0:4*maxCases-1];
	// Register model behind the USI bus
	logic [31:0] regMem [0:65535];
	// Observed USI writes and UFI burst words
	logic [31:0] wrAdrsQ[$], wrDataQ[$], bAdrsQ[$], bDataQ[$];
	logic [31:0] randState;
	int errCount, checkCount;
	// Activity flags and watchdog start
	bit misoSeen, windowSeen, casesLoaded;
	realtime watchLimit;

	SpiClkGen clkGen (.sysClk(sysClk), .arstN(arstN));

	SpiSlaveUnit #(.busAdrsBit(16)) dut (.sysClk(sysClk), .arstN(arstN), .spiSck(spiSck),
		.spiCsN(spiCsN), .spiMosi(spiMosi), .spiMiso(spiMiso), .usiRd(usiRd), .usiWd(usiWd),
		.usiAdrs(usiAdrs), .usiWEd(usiWEd), .ufiWd(ufiWd), .ufiAdrs(ufiAdrs),
		.ufiWEd(ufiWEd), .ufiWVd(ufiWVd));

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Register contents before any write
	function automatic logic [31:0] regFill(input logic [15:0] a);
		return {a ^ 16'hA5A5, a};
	endfunction

	task automatic drawPayload(output logic [31:0] w);
		randState = xorshift(randState);
		w = randState;
	endtask

	task automatic compareWord(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checkCount++;
		assert (got === exp)
		else
		begin
			errCount++;
			$display("[ERROR] %0d ns: %s is %08h, expected %08h",
				$time, what, got, exp);
		end
	endtask

	// Mode 0 bits with MISO taken just before each rise
	task automatic shiftWord(input logic [31:0] w, input int nBits, output logic [31:0] rx);
		rx = '0;
		for (int i = 0; i < nBits; i++)
		begin
			spiMosi = w[31-i];
			repeat (halfBit) @(negedge sysClk);
			rx = {rx[30:0], spiMiso};
			spiSck = 1'b1;
			repeat (halfBit) @(negedge sysClk);
			spiSck = 1'b0;
		end
	endtask

	//--------------------------------------
	// Register model and bus monitor
	//--------------------------------------
	assign usiRd = regMem[usiAdrs];

	always @(negedge sysClk)
	begin
		if (spiMiso)
			misoSeen = 1'b1;
		if (ufiWVd)
			windowSeen = 1'b1;
		if (usiWEd)
		begin
			wrAdrsQ.push_back(32'(usiAdrs));
			wrDataQ.push_back(usiWd);
			regMem[usiAdrs] = usiWd;
		end
		if (ufiWEd)
		begin
			assert (ufiWVd)
			else
			begin
				errCount++;
				$display("[ERROR] %0d ns: UFI strobe with window low", $time);
			end
			bAdrsQ.push_back(ufiAdrs);
			bDataQ.push_back(ufiWd);
		end
	end

	//--------------------------------------
	// One frame and its checks
	//--------------------------------------
	task automatic runCase(input logic [3:0] kind, input logic [31:0] adrs,
		input logic [15:0] count, input logic [31:0] value);
		logic [31:0] rx, w;
		logic [31:0] payload[$];
		int wrStart, bStart;
		wrStart = wrAdrsQ.size();
		bStart = bAdrsQ.size();
		misoSeen = 1'b0;
		spiCsN = 1'b0;
		repeat (halfBit) @(negedge sysClk);
		case (kind)
			4'h0, 4'h1, 4'h3:
			begin
				// Header then one word that carries the read data back
				shiftWord({kind[1:0], 14'd0, adrs[15:0]}, 32, rx);
				shiftWord(value, 32, rx);
			end
			4'h2:
			begin
				shiftWord({cmdUfiBurst, 14'd0, count}, 32, rx);
				shiftWord(adrs, 32, rx);
				for (int i = 0; i < int'(count) + int'(value); i++)
				begin
					drawPayload(w);
					payload.push_back(w);
					shiftWord(w, 32, rx);
				end
			end
			default:
			begin
				// Write frame cut inside its data word
				shiftWord({cmdUsiWrite, 14'd0, adrs[15:0]}, 32, rx);
				drawPayload(w);
				shiftWord(w, int'(value), rx);
			end
		endcase
		repeat (halfBit) @(negedge sysClk);
		spiCsN = 1'b1;
		spiMosi = 1'b0;
		// Let the pipeline drain before looking at the buses
		repeat (2 * halfBit) @(negedge sysClk);
		compareWord("USI write count", 32'(wrAdrsQ.size() - wrStart),
			32'(kind == 4'h0));
		if (kind == 4'h0 && wrAdrsQ.size() > wrStart)
		begin
			compareWord("USI write address", wrAdrsQ[wrStart], {16'd0, adrs[15:0]});
			compareWord("USI write data", wrDataQ[wrStart], value);
		end
		if (kind == 4'h1)
			compareWord("USI read data on MISO", rx, value);
		compareWord("UFI write count", 32'(bAdrsQ.size() - bStart),
			kind == 4'h2 ? 32'(count) : 32'd0);
		for (int i = 0; kind == 4'h2 && i < int'(count) && bStart + i < bAdrsQ.size();
			i++)
		begin
			compareWord("UFI write address", bAdrsQ[bStart+i], adrs + 32'(4 * i));
			compareWord("UFI write data", bDataQ[bStart+i], payload[i]);
		end
		compareWord("UFI window after frame", 32'(ufiWVd), 32'd0);
		if (kind == 4'h3)
			compareWord("MISO activity on reserved frame", 32'(misoSeen), 32'd0);
	endtask

	//--------------------------------------
	// Sequence
	//--------------------------------------
	initial
	begin
		int nCases;
		longint totalBits;
		spiSck = 1'b0;
		spiCsN = 1'b1;
		spiMosi = 1'b0;
		errCount = 0;
		checkCount = 0;
		randState = 32'd57;
		nCases = 0;
		totalBits = 0;
		for (int a = 0; a < 65536; a++)
			regMem[a] = regFill(16'(a));
		$readmemh("spiCases.txt", caseMem);
		// Kind f closes the list
		while (nCases < maxCases && caseMem[4*nCases] != 32'hF)
		begin
			if (caseMem[4*nCases] == 32'h2)
				totalBits += 32 * (2 + caseMem[4*nCases+2] + caseMem[4*nCases+3]);
			else if (caseMem[4*nCases] == 32'h4)
				totalBits += 32 + caseMem[4*nCases+3];
			else
				totalBits += 64;
			nCases++;
		end
		watchLimit = 1.5 * totalBits * 16 * 40.0;
		casesLoaded = 1'b1;
		// Idle bus after reset with CS inactive
		wait (arstN === 1'b1);
		misoSeen = 1'b0;
		windowSeen = 1'b0;
		compareWord("Outputs after reset", {28'd0, usiWEd, ufiWEd, ufiWVd, spiMiso}, 32'd0);
		repeat (32) @(negedge sysClk);
		compareWord("Strobes while idle", 32'(wrAdrsQ.size() + bAdrsQ.size()), 32'd0);
		compareWord("MISO while idle", 32'(misoSeen), 32'd0);
		compareWord("UFI window while idle", 32'(windowSeen), 32'd0);
		for (int c = 0; c < nCases; c++)
			runCase(caseMem[4*c][3:0], caseMem[4*c+1], caseMem[4*c+2][15:0],
				caseMem[4*c+3]);
		$display("Frames: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
			nCases, checkCount, errCount, dut.strobeAssert.failCount);
		if (errCount == 0 && dut.strobeAssert.failCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// Bound by the bit count of the case file
	initial
	begin
		wait (casesLoaded);
		#(watchLimit);
		$display("Timeout, frames still running after %0d ns", $time);
		$display("Test failed");
		$finish;
	end

endmodule

// File: spiCases.txt
// Columns in hex: kind, address, word count, value
// kind 0 write, 1 read, 2 burst, 3 reserved, 4 cut write frame, f end of list
// value is write data, expected read data, extra burst words or data bits sent
0 00000010 0000 deadbeef
1 00000010 0000 deadbeef
1 00001234 0000 b7911234
2 00004000 0004 00000002
4 00000020 0000 0000000d
1 00000020 0000 a5850020
3 00000030 0000 00000000
2 00010000 0000 00000001
0 000000f0 0000 12345678
1 000000f0 0000 12345678
4 00000040 0000 0000001f
2 00008000 0003 00000000
1 00000040 0000 a5e50040
3 00000050 0000 ffffffff
f 00000000 0000 00000000

// File: verilog.f
SpiPkg.sv
SpiFrameIf.sv
SpiFrameDecoder.sv
SpiBusExecutor.sv
SpiMisoResult.sv
SpiSlaveUnit.sv
SpiClkGen.sv
SpiUnitAssert.sv
SpiUnitTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the SPI slave unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/simSpiUnit

verilator --binary --timing --assert -Wno-fatal \
	--top-module SpiUnitTb -f verilog.f -o simSpiUnit
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./$SIM > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Result decided by the testbench message in the log
if grep -qx "Test passed" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
